/* verif/decodeInput.txt */
// Columns are instruction word, pc, flags, registers and expected immediate
// Flag digits are load cload cloadTags zeroExt indexed memSize, registers are rd ra rb bytes
002040C0 00001000 100000 010200 00000004
FFF86141 00001004 100100 020300 FFFFFFFF
020021C2 00001008 100001 030100 00000040
80008243 0000100C 100101 040400 FFFFF000
7FF902C4 00001010 100002 050800 00000FFF
0043E3C5 00001014 100102 071F00 00000008
0007E546 00001018 100003 0A3F00 00000000
00803FC7 0000101C 100103 3F0100 00000010
040820C8 00001020 100004 010100 00000081
00206149 00001024 100013 020304 00000000
202881C9 00001028 000013 030405 00000000
22404249 0000102C 110013 040208 00000000
001022CA 00001030 010003 050100 00000002
400863AE 00001034 001003 070300 00000801
220040AE 00001038 000003 010200 00000440
FFF0A04C 0000103C 100003 000500 FFFFFFFE
0000007F 00001040 000000 000000 00000000
00082080 00001044 000000 010100 00000001
2218414A 00001048 010003 020200 00000443
41FFFFC9 0000104C 100013 3F3F3F 00000000
400000CC 00001050 100003 010000 00000800
20282140 00001054 100000 020100 00000405
FE0061C3 00001058 100101 030300 FFFFFFC0
20000049 0000105C 000013 000000 00000000
8208A247 00001060 100103 040500 FFFFF041
0100E348 00001064 100004 060700 00000020
0000412E 00001068 000003 020200 00000000
200124C4 0000106C 100002 090900 00000400
7E0040C1 00001070 100100 010200 00000FC0
FFF881CA 00001074 010003 030400 FFFFFFFF
4000002E 00001078 001003 000000 00000800
220820C9 0000107C 110013 010101 00000000

/* verilog.f */
rtl/QuplsInstrPkg.sv
rtl/QuplsDecodePkg.sv
rtl/QuplsDecodeLoad.sv
rtl/QuplsDecodeFields.sv
rtl/QuplsDecodeQueue.sv
rtl/QuplsDecodeStage.sv
rtl/QuplsDecodeTop.sv
verif/QuplsDecodeTb.sv

/* Makefile */
# Verilator build and run of the load decode testbench
TOP = QuplsDecodeTb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f -Mdir $(OBJ) -o V$(TOP)

# The executable exits non-zero when the testbench hits $fatal
run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

/* verif/QuplsDecodeTb.sv */
// ========================================
// Load decode testbench
// Feeds fetch packets from a vector file under input credits,
// returns output credits at random and checks every record
// ========================================

`timescale 1ns/10ps
`default_nettype none

module QuplsDecodeTb;

	import QuplsInstrPkg::*;
	import QuplsDecodePkg::*;

	localparam int InDepth = DefInDepth;
	localparam int OutDepth = DefOutDepth;
	localparam int OutCredits = DefOutCredits;
	localparam int NumVec = 32;
	// Instruction, pc, flags, registers and immediate
	localparam int WordsPerVec = 5;
	localparam int TimeoutCycles = NumVec * 40 + 200;

	logic clk;
	logic arstN;
	logic inValid;
	fetch_packet_t inPkt;
	logic inCredit;
	logic outValid;
	decode_t outDec;
	logic outCredit;

	logic [31:0] vecMem [NumVec * WordsPerVec];
	fetch_packet_t pktList [NumVec];
	decode_t expList [NumVec];

	// Producer side bookkeeping
	int sendIdx;
	int inCreditsHeld;
	int inCreditTotal;
	logic newInCredit;
	// Consumer side bookkeeping
	int rcvIdx;
	int outCount;
	int retCount;
	int pendingCredits;
	int holdLeft;
	int cycles;

	QuplsDecodeTop #(
		.InDepth(InDepth),
		.OutDepth(OutDepth),
		.OutCredits(OutCredits)
	) uut
	(
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inPkt(inPkt),
		.inCredit(inCredit),
		.outValid(outValid),
		.outDec(outDec),
		.outCredit(outCredit)
	);

	always
	begin
		#4 clk = ~clk;
	end

	// ========================================
	// Failure reporting and checks
	// ========================================

	task automatic stopWithFailure();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped after a failed check");
	endtask

	task automatic checkDecode(input decode_t got, input decode_t exp, input int idx);
		if (got !== exp)
		begin
			$display("ERROR at %0t ns: record %0d with pc %h decoded wrong", $time, idx, exp.pc);
			$display("  got pc=%h ld=%b cl=%b ct=%b ze=%b ix=%b sz=%0d", got.pc, got.load,
				got.cload, got.cloadTags, got.zeroExt, got.indexed, got.memSize);
			$display("      rd=%0d ra=%0d rb=%0d imm=%h", got.rd, got.ra, got.rb, got.imm);
			$display("  exp pc=%h ld=%b cl=%b ct=%b ze=%b ix=%b sz=%0d", exp.pc, exp.load,
				exp.cload, exp.cloadTags, exp.zeroExt, exp.indexed, exp.memSize);
			$display("      rd=%0d ra=%0d rb=%0d imm=%h", exp.rd, exp.ra, exp.rb, exp.imm);
			stopWithFailure();
		end
	endtask

	task automatic checkCreditCount(input string what, input int got, input int exp);
		if (got != exp)
		begin
			$display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			stopWithFailure();
		end
	endtask

	// Both handshake outputs must stay low while the queues come out of reset
	task automatic checkQuiet(input string when);
		if (outValid !== 1'b0 || inCredit !== 1'b0)
		begin
			$display("ERROR at %0t ns: outValid=%b inCredit=%b %s", $time, outValid,
				inCredit, when);
			stopWithFailure();
		end
	endtask

	// ========================================
	// Vectors and cycle pacing
	// ========================================

	// Flags hold one hex digit per field, registers one byte each
	task automatic loadVectors();
		logic [31:0] flags;
		logic [31:0] regs;
		int base;
		$readmemh("verif/decodeInput.txt", vecMem);
		for (int i = 0; i < NumVec; i++)
		begin
			base = i * WordsPerVec;
			flags = vecMem[base + 2];
			regs = vecMem[base + 3];
			pktList[i].instr = instruction_t'(vecMem[base]);
			pktList[i].pc = vecMem[base + 1];
			expList[i].pc = vecMem[base + 1];
			expList[i].load = flags[20];
			expList[i].cload = flags[16];
			expList[i].cloadTags = flags[12];
			expList[i].zeroExt = flags[8];
			expList[i].indexed = flags[4];
			expList[i].memSize = mem_size_t'(flags[2:0]);
			expList[i].rd = regs[21:16];
			expList[i].ra = regs[13:8];
			expList[i].rb = regs[5:0];
			expList[i].imm = vecMem[base + 4];
		end
	endtask

	task automatic nextCycle();
		@(negedge clk);
		cycles++;
		if (cycles > TimeoutCycles)
		begin
			$display("Timeout after %0d cycles with %0d of %0d records received",
				TimeoutCycles, rcvIdx, NumVec);
			stopWithFailure();
		end
	endtask

	// Outputs depend on registers only, so the falling edge sees this cycle's values
	task automatic sampleOutputs();
		newInCredit = (inCredit === 1'b1);
		if (newInCredit)
			inCreditTotal++;
		if (outValid === 1'b1)
		begin
			outCount++;
			if (outCount > retCount + OutCredits)
			begin
				$display("ERROR at %0t ns: %0d records sent against %0d credits", $time,
					outCount, retCount + OutCredits);
				stopWithFailure();
			end
			if (rcvIdx >= NumVec)
			begin
				$display("ERROR at %0t ns: record arrived after the last vector", $time);
				stopWithFailure();
			end
			checkDecode(outDec, expList[rcvIdx], rcvIdx);
			rcvIdx++;
			pendingCredits++;
		end
	endtask

	// A credit seen this cycle is spent from the next cycle on
	task automatic driveProducer();
		if (sendIdx < NumVec && inCreditsHeld > 0 && ($urandom % 4) != 0)
		begin
			inValid = 1'b1;
			inPkt = pktList[sendIdx];
			sendIdx++;
			inCreditsHeld--;
		end
		else
		begin
			inValid = 1'b0;
			inPkt = '0;
		end
		if (newInCredit)
			inCreditsHeld++;
		checkCreditCount("input credits over depth", (inCreditsHeld > InDepth) ? 1 : 0, 0);
	endtask

	// Consumer withholds credits for long stretches now and then
	task automatic driveConsumer();
		if (holdLeft > 0)
			holdLeft--;
		else if (($urandom % 48) == 0)
			holdLeft = 20 + ($urandom % 60);
		if (holdLeft == 0 && pendingCredits > 0 && ($urandom % 3) == 0)
		begin
			outCredit = 1'b1;
			pendingCredits--;
			retCount++;
		end
		else
			outCredit = 1'b0;
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial
	begin
		clk = 1'b0;
		arstN = 1'b0;
		inValid = 1'b0;
		inPkt = '0;
		outCredit = 1'b0;
		sendIdx = 0;
		inCreditsHeld = InDepth;
		inCreditTotal = 0;
		newInCredit = 1'b0;
		rcvIdx = 0;
		outCount = 0;
		retCount = 0;
		pendingCredits = 0;
		// Start under back-pressure so both queues fill and fetch stalls
		holdLeft = 60;
		cycles = 0;
		void'($urandom(32'h4e3d7660));
		loadVectors();

		repeat (5)
		begin
			nextCycle();
			checkQuiet("during reset");
		end
		arstN = 1'b1;
		nextCycle();
		checkQuiet("in the cycle after reset");

		while (rcvIdx < NumVec)
		begin
			nextCycle();
			sampleOutputs();
			driveProducer();
			driveConsumer();
		end

		// Idle a little longer to catch any extra record
		repeat (20)
		begin
			nextCycle();
			sampleOutputs();
			driveProducer();
			driveConsumer();
		end

		checkCreditCount("inCredit pulses", inCreditTotal, sendIdx);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/QuplsDecodeTop.sv */
// ========================================
// Load decode top level
// Input queue, decode stage and output queue in a row
// with credits routed between them
// ========================================

`timescale 1ns/10ps
`default_nettype none

module QuplsDecodeTop #(
	parameter int InDepth = QuplsDecodePkg::DefInDepth,
	parameter int OutDepth = QuplsDecodePkg::DefOutDepth,
	parameter int OutCredits = QuplsDecodePkg::DefOutCredits
)
(
	input logic clk,
	input logic arstN,
	input logic inValid,
	input QuplsDecodePkg::fetch_packet_t inPkt,
	output logic inCredit,
	output logic outValid,
	output QuplsDecodePkg::decode_t outDec,
	input logic outCredit
);

	import QuplsDecodePkg::*;

	// Input queue to decode stage
	logic pktValid;
	fetch_packet_t pkt;
	// Decode stage to output queue
	logic decValid;
	decode_t dec;
	// Output queue slot freed, returned to the input queue
	logic slotCredit;

	// Holds one credit per output queue slot, so a popped packet
	// always finds room after the decode stage
	QuplsDecodeQueue #(
		.Depth(InDepth),
		.Credits(OutDepth),
		.T(fetch_packet_t)
	) uInQueue
	(
		.clk(clk),
		.arstN(arstN),
		.enqValid(inValid),
		.enqData(inPkt),
		.enqCredit(inCredit),
		.deqValid(pktValid),
		.deqData(pkt),
		.retCredit(slotCredit)
	);

	QuplsDecodeStage uStage
	(
		.clk(clk),
		.arstN(arstN),
		.inValid(pktValid),
		.inPkt(pkt),
		.outValid(decValid),
		.outDec(dec)
	);

	// Releases records against the consumer's credits
	QuplsDecodeQueue #(
		.Depth(OutDepth),
		.Credits(OutCredits),
		.T(decode_t)
	) uOutQueue
	(
		.clk(clk),
		.arstN(arstN),
		.enqValid(decValid),
		.enqData(dec),
		.enqCredit(slotCredit),
		.deqValid(outValid),
		.deqData(outDec),
		.retCredit(outCredit)
	);

endmodule

`default_nettype wire

/* rtl/QuplsDecodeStage.sv */
// ========================================
// Decode stage
// Runs the load classifier and field extractor and
// registers the combined record with its valid bit
// ========================================

`timescale 1ns/10ps
`default_nettype none

module QuplsDecodeStage
(
	input logic clk,
	input logic arstN,
	input logic inValid,
	input QuplsDecodePkg::fetch_packet_t inPkt,
	output logic outValid,
	output QuplsDecodePkg::decode_t outDec
);

	import QuplsDecodePkg::*;

	logic load;
	logic cload;
	logic cloadTags;
	logic zeroExt;
	logic indexed;
	mem_size_t memSize;
	logic [5:0] rd;
	logic [5:0] ra;
	logic [5:0] rb;
	logic [31:0] imm;
	// Record before the pipeline register
	decode_t dec;

	QuplsDecodeLoad uLoad
	(
		.instr(inPkt.instr),
		.load(load),
		.cload(cload),
		.cloadTags(cloadTags)
	);

	QuplsDecodeFields uFields
	(
		.instr(inPkt.instr),
		.memSize(memSize),
		.zeroExt(zeroExt),
		.indexed(indexed),
		.rd(rd),
		.ra(ra),
		.rb(rb),
		.imm(imm)
	);

	always_comb
	begin
		dec.pc = inPkt.pc;
		dec.load = load;
		dec.cload = cload;
		dec.cloadTags = cloadTags;
		dec.zeroExt = zeroExt;
		dec.indexed = indexed;
		dec.memSize = memSize;
		dec.rd = rd;
		dec.ra = ra;
		dec.rb = rb;
		dec.imm = imm;
	end

	// Valid follows its input one cycle later, there is no stall
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			outValid <= 1'b0;
		else
			outValid <= inValid;
	end

	// Record is only captured for a valid packet
	always_ff @(posedge clk)
	begin
		if (inValid)
			outDec <= dec;
	end

endmodule

`default_nettype wire

/* rtl/QuplsDecodeQueue.sv */
// ========================================
// Credit queue
// Circular FIFO that returns a credit upstream on every
// pop and only pops while it holds downstream credit
// ========================================

`timescale 1ns/10ps
`default_nettype none

module QuplsDecodeQueue #(
	parameter int Depth = 4,
	parameter int Credits = 2,
	parameter type T = logic
)
(
	input logic clk,
	input logic arstN,
	input logic enqValid,
	input T enqData,
	output logic enqCredit,
	output logic deqValid,
	output T deqData,
	input logic retCredit
);

	localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CntW = $clog2(Depth + 1);
	localparam int CrdW = $clog2(Credits + 1);

	// Storage, written on every valid enqueue
	T mem [Depth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	// Entries held right now
	logic [CntW-1:0] count;
	// Downstream slots this queue may still fill
	logic [CrdW-1:0] credits;
	logic pop;

	// Advance a pointer and wrap at Depth, which need not be a power of two
	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
		nextPtr = (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// ========================================
	// Dequeue side
	// ========================================

	// Pop whenever an entry waits and a downstream slot is reserved
	assign pop = (count != '0) && (credits != '0);
	assign deqValid = pop;
	assign deqData = mem[rdPtr];

	// The freed slot goes straight back to the producer as a credit
	assign enqCredit = pop;

	always_ff @(posedge clk)
	begin
		if (enqValid)
			mem[wrPtr] <= enqData;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			credits <= CrdW'(Credits);
		end
		else
		begin
			if (enqValid)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			// Enqueue and pop in one cycle leave the count alone
			case ({enqValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Spending and a returned credit in one cycle cancel out
			case ({pop, retCredit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/QuplsDecodeFields.sv */
// ========================================
// Load field extractor
// Pulls registers, access size, zero extension, indexed
// mode and the sign-extended immediate from a word
// ========================================

`timescale 1ns/10ps
`default_nettype none

module QuplsDecodeFields
(
	input QuplsInstrPkg::instruction_t instr,
	output QuplsDecodePkg::mem_size_t memSize,
	output logic zeroExt,
	output logic indexed,
	output logic [5:0] rd,
	output logic [5:0] ra,
	output logic [5:0] rb,
	output logic [31:0] imm
);

	import QuplsInstrPkg::*;
	import QuplsDecodePkg::*;

	// Immediate field of the non-indexed forms, func on top of rb
	logic [ImmBits-1:0] immField;

	assign immField = {instr.func, instr.rb};

	// Access size depends on the opcode alone
	always_comb
	begin
		case (instr.opcode)
			OP_LDB, OP_LDBU:
				memSize = MS_BYTE;
			OP_LDW, OP_LDWU:
				memSize = MS_WYDE;
			OP_LDT, OP_LDTU:
				memSize = MS_TETRA;
			OP_LDO, OP_LDOU, OP_LDX, OP_JSRI, OP_CLOAD, OP_CAP:
				memSize = MS_OCTA;
			OP_LDH:
				memSize = MS_HEXI;
			default:
				memSize = MS_BYTE;
		endcase
	end

	// Only the U forms zero extend, the rest sign extend
	always_comb
	begin
		case (instr.opcode)
			OP_LDBU, OP_LDWU, OP_LDTU, OP_LDOU:
				zeroExt = 1'b1;
			default:
				zeroExt = 1'b0;
		endcase
	end

	assign indexed = (instr.opcode == OP_LDX);
	assign rd = instr.rd;
	assign ra = instr.ra;

	// Indexed form uses rb as the index register and has no displacement
	// Other forms spend the rb bits on the immediate, so rb reads as zero
	always_comb
	begin
		if (indexed)
		begin
			rb = instr.rb;
			imm = '0;
		end
		else
		begin
			rb = '0;
			imm = {{(32 - ImmBits){immField[ImmBits-1]}}, immField};
		end
	end

endmodule

`default_nettype wire

/* rtl/QuplsDecodeLoad.sv */
// ========================================
// Load classifier
// Marks plain loads, capability loads and capability
// tag loads from the opcode and function fields
// ========================================

`timescale 1ns/10ps
`default_nettype none

module QuplsDecodeLoad
(
	input QuplsInstrPkg::instruction_t instr,
	output logic load,
	output logic cload,
	output logic cloadTags
);

	import QuplsInstrPkg::*;

	// Plain loads
	// Every sized load counts, and JSRI too since it reads its target
	// The indexed opcode counts unless func turns it into an address calculation
	always_comb
	begin
		case (instr.opcode)
			OP_JSRI,
			OP_LDB, OP_LDBU,
			OP_LDW, OP_LDWU,
			OP_LDT, OP_LDTU,
			OP_LDO, OP_LDOU,
			OP_LDH:
				load = 1'b1;
			OP_LDX:
				load = (instr.func != FN_LDAX);
			default:
				load = 1'b0;
		endcase
	end

	// Capability loads, immediate form or indexed form with FN_CLOADX
	always_comb
	begin
		case (instr.opcode)
			OP_CLOAD:
				cload = 1'b1;
			OP_LDX:
				cload = (instr.func == FN_CLOADX);
			default:
				cload = 1'b0;
		endcase
	end

	// Tag loads only come from the capability group
	// This is not the same test as cload above
	always_comb
	begin
		cloadTags = (instr.opcode == OP_CAP) && (instr.func == FN_CLOADTAGS);
	end

endmodule

`default_nettype wire

/* rtl/QuplsDecodePkg.sv */
// ========================================
// Qupls decode types
// Fetch packet, decoded load record, memory size codes
// and the queue depths used by default at the top level
// ========================================

`default_nettype none

package QuplsDecodePkg;

	// One fetched instruction and the address it came from
	typedef struct packed
	{
		QuplsInstrPkg::instruction_t instr;
		logic [31:0] pc;
	} fetch_packet_t;

	// Access size of a memory operation
	// Capability loads, the tag load and JSRI move an octa
	typedef enum logic [2:0]
	{
		MS_BYTE = 3'd0,
		MS_WYDE = 3'd1,
		MS_TETRA = 3'd2,
		MS_OCTA = 3'd3,
		MS_HEXI = 3'd4
	} mem_size_t;

	// Record leaving the decode stage
	// The immediate is already sign extended to the full width
	typedef struct packed
	{
		logic [31:0] pc;
		logic load;
		logic cload;
		logic cloadTags;
		logic zeroExt;
		logic indexed;
		mem_size_t memSize;
		logic [5:0] rd;
		logic [5:0] ra;
		logic [5:0] rb;
		logic [31:0] imm;
	} decode_t;

	// Queue sizes that the top level hands down
	localparam int DefInDepth = 4;
	localparam int DefOutDepth = 4;
	localparam int DefOutCredits = 2;

endpackage

`default_nettype wire

/* rtl/QuplsInstrPkg.sv */
// ========================================
// Qupls instruction definitions
// Layout of the 32-bit instruction word and the opcode and
// function codes of the load family and capability group
// ========================================

`default_nettype none

package QuplsInstrPkg;

	// Major opcodes that the load decoder looks at
	// The sized loads sit together so the U forms differ in bit 0 only
	typedef enum logic [6:0]
	{
		OP_LDB = 7'h40,
		OP_LDBU = 7'h41,
		OP_LDW = 7'h42,
		OP_LDWU = 7'h43,
		OP_LDT = 7'h44,
		OP_LDTU = 7'h45,
		OP_LDO = 7'h46,
		OP_LDOU = 7'h47,
		OP_LDH = 7'h48,
		// Indexed load, func picks the variant
		OP_LDX = 7'h49,
		// Capability load with an immediate displacement
		OP_CLOAD = 7'h4A,
		// Jump to subroutine through a pointer loaded from memory
		OP_JSRI = 7'h4C,
		// Capability group, func picks the operation
		OP_CAP = 7'h2E,
		OP_NOP = 7'h7F
	} opcode_t;

	// Function codes
	// FN_LDAX and FN_CLOADX live under OP_LDX
	// FN_CLOADTAGS lives under OP_CAP
	typedef enum logic [6:0]
	{
		// Load address indexed, computes an address and reads nothing
		FN_LDAX = 7'h10,
		// Capability load, indexed form
		FN_CLOADX = 7'h11,
		// Load the tag bits of a block of capabilities
		FN_CLOADTAGS = 7'h20
	} func_t;

	// ========================================
	// Instruction word
	// ========================================

	// Opcode sits in the low bits and func in the high bits
	// For non-indexed forms func and rb together hold a 13-bit immediate
	typedef struct packed
	{
		logic [6:0] func;
		logic [5:0] rb;
		logic [5:0] ra;
		logic [5:0] rd;
		opcode_t opcode;
	} instruction_t;

	// Width of the immediate carried by func and rb
	localparam int ImmBits = 13;

endpackage

`default_nettype wire
